//--- Makefile
# Verilator build and run of the r5p core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --top-module r5p_tb -f src.f --Mdir obj_dir
	./obj_dir/Vr5p_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- src.f
src/r5p_pkg.sv
src/r5p_decoder.sv
src/r5p_alu.sv
src/r5p_gpr.sv
src/r5p_pc.sv
src/r5p_ctrl.sv
src/r5p_core.sv
verification/r5p_tb.sv

//--- src/r5p_alu.sv
/*
  r5p alu
  operand mux, one shared adder for add/sub/compare,
  bitwise logic and a barrel shifter
*/

`timescale 1ns/100ps

module r5p_alu import r5p_pkg::*; (
  input  alu_op_t         alu_op,
  input  alu_sel_t        alu_sel,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] rs1,
  input  logic [XLEN-1:0] rs2,
  input  logic [XLEN-1:0] imm,
  output logic [XLEN-1:0] rd,
  output logic [XLEN:0]   sum    // adder result with extension bit
);

  logic [XLEN-1:0] op1;   // selected operands
  logic [XLEN-1:0] op2;
  logic            sgn;   // sign extension of adder operands
  logic            inv;   // subtract by inverting op2
  logic [XLEN:0]   ao1;   // adder operands, one bit wider
  logic [XLEN:0]   ao2;
  logic [XLOG-1:0] sa;    // shift amount

  //////////////////////////////////////////////////////////////////////
  // operands
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_sel)
      AI_R1_R2: begin op1 = rs1;  op2 = rs2; end
      AI_R1_II: begin op1 = rs1;  op2 = imm; end
      AI_Z0_IU: begin op1 = '0;   op2 = imm; end  // lui passes imm
      AI_PC_IU,
      AI_PC_IJ: begin op1 = pc;   op2 = imm; end
      default:  begin op1 = '0;   op2 = '0;  end
    endcase
  end

  // sltu compares zero extended, everything else sign extended
  assign sgn = (alu_op != AO_SLTU);
  assign ao1 = {sgn & op1[XLEN-1], op1};
  assign ao2 = {sgn & op2[XLEN-1], op2};

  //////////////////////////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      AO_SUB,
      AO_SLT,
      AO_SLTU: inv = 1'b1;
      default: inv = 1'b0;
    endcase
  end

  // two's complement subtract, carry in through inv
  assign sum = ao1 + (inv ? ~ao2 : ao2) + {{XLEN{1'b0}}, inv};

  // register form shifts by rs2, immediate form by shamt
  assign sa = (alu_sel == AI_R1_II) ? imm[XLOG-1:0] : rs2[XLOG-1:0];

  //////////////////////////////////////////////////////////////////////
  // result
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      AO_ADD,
      AO_SUB:  rd = sum[XLEN-1:0];
      AO_SLT,
      AO_SLTU: rd = {{(XLEN-1){1'b0}}, sum[XLEN]};  // top bit is the borrow
      AO_AND:  rd = op1 & op2;
      AO_OR:   rd = op1 | op2;
      AO_XOR:  rd = op1 ^ op2;
      AO_SLL:  rd = rs1 << sa;
      AO_SRL:  rd = rs1 >> sa;
      AO_SRA:  rd = $signed(rs1) >>> sa;
      default: rd = '0;
    endcase
  end

  // a routed operand pair means the result feeds writeback or the pc
  always_comb begin
    if (!$isunknown(alu_sel)) begin
      assert (alu_op inside {AO_ADD, AO_SUB, AO_SLT, AO_SLTU, AO_AND,
                             AO_OR, AO_XOR, AO_SLL, AO_SRL, AO_SRA})
        else $error("alu: unknown operation %b", alu_op);
    end
  end

endmodule

//--- src/r5p_core.sv
/*
  r5p core top
  ties controller, pc, decoder, register file and alu together
*/

`timescale 1ns/100ps

module r5p_core import r5p_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  logic            imem_ack,
  input  logic [XLEN-1:0] imem_rdata,
  output logic            imem_req,
  output logic [XLEN-1:0] imem_addr,
  output logic            retire,
  output logic [XLEN-1:0] retire_pc,
  output logic [4:0]      retire_rd,
  output logic [XLEN-1:0] retire_data,
  output logic            trap,
  output logic            busy
);

  logic [31:0]     instr;
  logic            exec;
  logic            illegal;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] link;
  alu_op_t         alu_op;
  alu_sel_t        alu_sel;
  logic [4:0]      rs1_idx;
  logic [4:0]      rs2_idx;
  logic [4:0]      rd_idx;
  logic [XLEN-1:0] imm;
  logic            wen;
  logic            jump;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] alu_rd;
  logic [XLEN:0]   alu_sum;
  logic [XLEN-1:0] wdata;
  logic            gpr_wen;

  r5p_ctrl u_ctrl (.clk, .rst_n, .start, .imem_ack, .imem_rdata, .illegal,
                   .imem_req, .exec, .retire, .trap, .busy, .instr);

  // pc moves only on retire, a trap leaves it on the illegal word
  r5p_pc u_pc (.clk, .rst_n, .exec(retire), .jump, .target(alu_sum[XLEN-1:0]), .pc, .link);

  r5p_decoder u_dec (.instr, .alu_op, .alu_sel, .rs1_idx, .rs2_idx, .rd_idx,
                     .imm, .wen, .jump, .illegal);

  r5p_gpr u_gpr (.clk, .rst_n, .wen(gpr_wen), .rs1_idx, .rs2_idx, .rd_idx,
                 .wdata, .rs1, .rs2);

  r5p_alu u_alu (.alu_op, .alu_sel, .pc, .rs1, .rs2, .imm, .rd(alu_rd), .sum(alu_sum));

  // writeback, jal stores the return address
  assign wdata   = jump ? link : alu_rd;
  assign gpr_wen = exec && wen;

  assign imem_addr   = pc;      // stable until pc moves on exec
  assign retire_pc   = pc;
  assign retire_rd   = rd_idx;
  assign retire_data = wdata;

endmodule

//--- src/r5p_ctrl.sv
/*
  r5p controller
  FSM for fetch, memory wait, execute and trap halt,
  holds the instruction register
*/

`timescale 1ns/100ps

module r5p_ctrl import r5p_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  logic            imem_ack,
  input  logic [XLEN-1:0] imem_rdata,
  input  logic            illegal,    // from decode of instr
  output logic            imem_req,
  output logic            exec,
  output logic            retire,
  output logic            trap,
  output logic            busy,
  output logic [31:0]     instr
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        instr_load;  // capture fetched word

  always_ff @(posedge clk) begin
    if (!rst_n) state <= ST_IDLE;
    else state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (start) state_nxt = ST_FETCH;
      ST_FETCH: state_nxt = ST_WAIT;           // request goes out here
      ST_WAIT:  if (imem_ack) state_nxt = ST_EXEC;
      ST_EXEC:  state_nxt = illegal ? ST_HALT : ST_FETCH;
      ST_HALT:  if (start) state_nxt = ST_IDLE; // pc kept for resume
      default:  state_nxt = ST_IDLE;
    endcase
  end

  // instruction register, loaded in the ack cycle
  assign instr_load = (state == ST_WAIT) && imem_ack;

  always_ff @(posedge clk) begin
    if (instr_load) instr <= imem_rdata;
  end

  // strobes decoded from state
  assign imem_req = (state == ST_FETCH);
  assign exec     = (state == ST_EXEC);
  assign retire   = exec && !illegal;
  assign trap     = exec && illegal;
  assign busy     = (state == ST_FETCH) || (state == ST_WAIT) || (state == ST_EXEC);

  // memory answers only the outstanding request
  ack_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
                                imem_ack |-> state == ST_WAIT)
    else $error("ctrl: memory ack outside the wait state");

  // decode settled before execute picks retire or trap
  exec_decoded: assert property (@(posedge clk) disable iff (!rst_n)
                                 exec |-> !$isunknown(illegal))
    else $error("ctrl: unknown decode during execute");

endmodule

//--- src/r5p_decoder.sv
/*
  r5p instruction decoder
  turns one RV32I word into alu controls, register indexes,
  the selected immediate and the write, jump and illegal flags
*/

`timescale 1ns/100ps

module r5p_decoder import r5p_pkg::*; (
  input  logic [31:0]     instr,
  output alu_op_t         alu_op,
  output alu_sel_t        alu_sel,
  output logic [4:0]      rs1_idx,
  output logic [4:0]      rs2_idx,
  output logic [4:0]      rd_idx,
  output logic [XLEN-1:0] imm,
  output logic            wen,
  output logic            jump,
  output logic            illegal
);

  opc_t            opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            alt;      // funct7 bit 5, sub/sra select
  logic            f7_rest;  // any other funct7 bit set
  alu_op_t         f3_op;    // base operation from funct3
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_sh;   // shamt, zero extended

  // instruction fields
  assign opcode  = opc_t'(instr[6:0]);
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign alt     = funct7[5];
  assign f7_rest = |{funct7[6], funct7[4:0]};

  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];
  assign rd_idx  = instr[11:7];

  // immediates, all sign extended from bit 31
  assign imm_i  = {{(XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u  = {instr[31:12], 12'h000};
  assign imm_j  = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_sh = {{(XLEN-XLOG){1'b0}}, instr[20 +: XLOG]};

  // funct3 to operation, shared by OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  f3_op = AO_ADD;
      3'b001:  f3_op = AO_SLL;
      3'b010:  f3_op = AO_SLT;
      3'b011:  f3_op = AO_SLTU;
      3'b100:  f3_op = AO_XOR;
      3'b101:  f3_op = AO_SRL;
      3'b110:  f3_op = AO_OR;
      default: f3_op = AO_AND;
    endcase
  end

  always_comb begin
    alu_op  = f3_op;
    alu_sel = AI_R1_R2;
    imm     = imm_i;
    wen     = 1'b1;   // every legal instruction writes rd
    jump    = 1'b0;
    illegal = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_sel = AI_R1_R2;
        if (f7_rest) begin
          illegal = 1'b1;
        end else if (alt) begin
          if (funct3 == 3'b000) alu_op = AO_SUB;
          else if (funct3 == 3'b101) alu_op = AO_SRA;
          else illegal = 1'b1;  // no alternate form
        end
      end
      OPC_OP_IMM: begin
        alu_sel = AI_R1_II;
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          imm = imm_sh;  // shifts carry funct7 in the immediate
          if (f7_rest || (alt && funct3 == 3'b001)) illegal = 1'b1;
          else if (alt) alu_op = AO_SRA;
        end
      end
      OPC_LUI: begin
        alu_op  = AO_ADD;
        alu_sel = AI_Z0_IU;
        imm     = imm_u;
      end
      OPC_AUIPC: begin
        alu_op  = AO_ADD;
        alu_sel = AI_PC_IU;
        imm     = imm_u;
      end
      OPC_JAL: begin
        alu_op  = AO_ADD;  // target on the alu sum
        alu_sel = AI_PC_IJ;
        imm     = imm_j;
        jump    = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      wen  = 1'b0;
      jump = 1'b0;
    end
  end

endmodule

//--- src/r5p_gpr.sv
/*
  r5p register file
  x1..x31 with two async read ports and one write port, x0 reads zero
*/

`timescale 1ns/100ps

module r5p_gpr import r5p_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wen,
  input  logic [4:0]      rs1_idx,
  input  logic [4:0]      rs2_idx,
  input  logic [4:0]      rd_idx,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] rs1,
  output logic [XLEN-1:0] rs2
);

  logic [XLEN-1:0] regs [1:31];  // no storage behind x0

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd_idx != 5'd0) begin  // writes to x0 dropped here
      regs[rd_idx] <= wdata;
    end
  end

  // combinational reads
  assign rs1 = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
  assign rs2 = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

//--- src/r5p_pc.sv
/*
  r5p program counter
  steps by four or loads a jump target on the exec strobe
*/

`timescale 1ns/100ps

module r5p_pc import r5p_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            exec,
  input  logic            jump,
  input  logic [XLEN-1:0] target,
  output logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] link     // pc + 4, also the jal return value
);

  assign link = pc + XLEN'(4);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= PC_RESET;
    end else if (exec) begin
      pc <= jump ? target : link;  // held while fetching or halted
    end
  end

  // jump targets come from the alu, so misalignment would show here
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc: misaligned address %h", pc);

endmodule

//--- src/r5p_pkg.sv
/*
  r5p shared definitions
  widths, reset address and the encodings used by the RV32I execute core
*/

package r5p_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and reset values
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;                   // data and address width
  localparam int unsigned XLOG = 5;                    // shift amount width
  localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000; // first fetch address

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // major opcodes, RISC-V values
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // register-register
    OPC_OP_IMM = 7'b0010011,  // register-immediate
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111
  } opc_t;

  // alu operations
  typedef enum logic [3:0] {
    AO_ADD  = 4'd0,
    AO_SUB  = 4'd1,
    AO_SLT  = 4'd2,   // signed compare on adder carry-out
    AO_SLTU = 4'd3,   // unsigned compare, same adder
    AO_AND  = 4'd4,
    AO_OR   = 4'd5,
    AO_XOR  = 4'd6,
    AO_SLL  = 4'd7,
    AO_SRL  = 4'd8,
    AO_SRA  = 4'd9
  } alu_op_t;

  // operand routing into the alu
  typedef enum logic [2:0] {
    AI_R1_R2 = 3'd0,  // rs1 with rs2
    AI_R1_II = 3'd1,  // rs1 with I immediate
    AI_Z0_IU = 3'd2,  // zero with U immediate (lui)
    AI_PC_IU = 3'd3,  // pc with U immediate (auipc)
    AI_PC_IJ = 3'd4   // pc with J immediate (jal)
  } alu_sel_t;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_FETCH = 3'd1,
    ST_WAIT  = 3'd2,
    ST_EXEC  = 3'd3,
    ST_HALT  = 3'd4
  } ctrl_state_t;

endpackage

//--- verification/r5p_tb.sv
/*
  r5p core testbench
  random RV32I program in a 64-word memory with random ack delay,
  reference model of pc and registers, checked on every retire
*/

`timescale 1ns/100ps

module r5p_tb import r5p_pkg::*; ();

  localparam int STEP_LIMIT = 20;    // cycles allowed per instruction
  localparam int RETIRE_LIMIT = 100; // program has at most 63 instructions

  logic            clk = 1'b0;
  logic            rst_n = 1'b0;
  logic            start = 1'b0;
  logic            imem_ack = 1'b0;
  logic [XLEN-1:0] imem_rdata = '0;
  logic            imem_req;
  logic [XLEN-1:0] imem_addr;
  logic            retire;
  logic [XLEN-1:0] retire_pc;
  logic [4:0]      retire_rd;
  logic [XLEN-1:0] retire_data;
  logic            trap;
  logic            busy;

  int          seed;
  logic [31:0] mem [64];         // instruction memory
  logic [2:0]  ack_delay [64];   // per request, 1 to 4 cycles
  logic [2:0]  ack_cnt = 3'd0;
  logic [5:0]  req_count = 6'd0;
  logic [31:0] req_addr = '0;

  logic [31:0] model_regs [32];  // architecture state seen by the checker
  logic [31:0] model_pc = '0;
  int          predicted_count = 0;
  logic [31:0] predicted_halt_pc = '0;
  int          error_count = 0;
  int          retire_count = 0;
  int          trap_count = 0;
  logic        idle_phase = 1'b0;  // before start
  logic        halt_phase = 1'b0;  // after the trap

  r5p_core UUT (.clk, .rst_n, .start, .imem_ack, .imem_rdata, .imem_req, .imem_addr,
                .retire, .retire_pc, .retire_rd, .retire_data, .trap, .busy);

  always #20 clk = ~clk;  // 40 ns period

  //////////////////////////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////////////////////////

  // one RV32I step: rd, its value and the next pc
  function automatic void ref_exec(input logic [31:0] pc, input logic [31:0] instr,
                                   input logic [31:0] regs [32], output logic [4:0] rd,
                                   output logic [31:0] data, output logic [31:0] next_pc,
                                   output logic legal);
    logic [31:0] a;
    logic [31:0] b;
    logic        is_reg;
    a       = regs[instr[19:15]];
    b       = regs[instr[24:20]];
    is_reg  = (instr[6:0] == OPC_OP);
    rd      = instr[11:7];
    data    = '0;
    next_pc = pc + 32'd4;
    legal   = 1'b1;
    case (instr[6:0])
      OPC_OP, OPC_OP_IMM: begin
        if (!is_reg) b = {{20{instr[31]}}, instr[31:20]};  // I immediate
        case (instr[14:12])
          3'd0: data = (is_reg && instr[30]) ? a - b : a + b;
          3'd1: data = a << b[4:0];
          3'd2: data = {31'b0, $signed(a) < $signed(b)};
          3'd3: data = {31'b0, a < b};
          3'd4: data = a ^ b;
          3'd5: begin
            if (instr[30]) data = $signed(a) >>> b[4:0];
            else data = a >> b[4:0];
          end
          3'd6: data = a | b;
          3'd7: data = a & b;
        endcase
      end
      OPC_LUI:   data = {instr[31:12], 12'h000};
      OPC_AUIPC: data = pc + {instr[31:12], 12'h000};
      OPC_JAL: begin
        data    = pc + 32'd4;  // link
        next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: legal = 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_quiet();
    check_value("imem_req", 32'(imem_req), 32'd0);
    check_value("retire", 32'(retire), 32'd0);
    check_value("trap", 32'(trap), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
  endtask

  // compares on every retire, samples before the edge updates state
  always @(posedge clk) begin
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic [31:0] exp_next;
    logic        exp_legal;
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) model_regs[i] = '0;
      model_pc = PC_RESET;
    end else begin
      if (imem_req) check_value("imem_addr", imem_addr, model_pc);  // fetch of the model pc
      if (retire) begin
        ref_exec(model_pc, mem[model_pc[7:2]], model_regs, exp_rd, exp_data, exp_next,
                 exp_legal);
        if (!exp_legal) begin
          error_count++;
          $display("retire at %0t of a word the model decodes as illegal", $time);
        end
        check_value("retire_pc", retire_pc, model_pc);
        check_value("retire_rd", 32'(retire_rd), 32'(exp_rd));
        check_value("retire_data", retire_data, exp_data);
        check_value("busy", 32'(busy), 32'd1);
        if (exp_rd != 5'd0) model_regs[exp_rd] = exp_data;  // x0 stays zero
        model_pc = exp_next;
        retire_count++;
      end
      if (trap) begin
        trap_count++;
        check_value("trap pc", retire_pc, model_pc);
        check_value("busy", 32'(busy), 32'd1);
      end
    end
    if (idle_phase) begin
      check_quiet();
      check_value("imem_addr", imem_addr, PC_RESET);
    end
    if (halt_phase) begin
      check_quiet();
      check_value("imem_addr", imem_addr, model_pc);  // pc stays on the illegal word
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    imem_ack <= 1'b0;
    if (!rst_n) begin
      ack_cnt <= 3'd0;
    end else if (ack_cnt != 3'd0) begin
      ack_cnt <= ack_cnt - 3'd1;
      if (ack_cnt == 3'd1) begin
        imem_ack   <= 1'b1;
        imem_rdata <= mem[req_addr[7:2]];
      end
    end else if (imem_req) begin
      req_addr  <= imem_addr;
      ack_cnt   <= ack_delay[req_count] - 3'd1;  // ack lands d cycles after the request
      req_count <= req_count + 6'd1;
      if (ack_delay[req_count] == 3'd1) begin  // answer in the very next cycle
        imem_ack   <= 1'b1;
        imem_rdata <= mem[imem_addr[7:2]];
      end
    end
  end

  // random legal program, forward jumps only, illegal zero word last
  task automatic fill_memory();
    logic [31:0] r;
    logic [31:0] s;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [20:0] joff;
    int unsigned span;
    int unsigned k;
    for (int i = 0; i < 63; i++) begin
      r     = $random(seed);
      s     = $random(seed);
      kind  = r[3:0];
      rd    = r[8:4];
      rs1   = r[13:9];
      rs2   = r[18:14];
      f3    = r[21:19];
      imm12 = s[11:0];
      imm20 = s[31:12];
      if (kind < 4'd6) begin
        mem[i] = {((f3 == 3'd0 || f3 == 3'd5) && r[31]) ? 7'h20 : 7'h00,
                  rs2, rs1, f3, rd, OPC_OP};
      end else if (kind < 4'd11) begin
        if (f3 == 3'd1 || f3 == 3'd5)   // shamt 0..31, sra only on funct3 5
          imm12 = {(f3 == 3'd5 && r[31]) ? 7'h20 : 7'h00, imm12[4:0]};
        mem[i] = {imm12, rs1, f3, rd, OPC_OP_IMM};
      end else if (kind < 4'd13) begin
        case (r[23:22])                 // signed edge values now and then
          2'd0: imm20 = 20'h80000;
          2'd1: imm20 = 20'h7ffff;
          2'd2: imm20 = 20'hfffff;
          default: ;
        endcase
        mem[i] = {imm20, rd, OPC_LUI};
      end else if (kind == 4'd13) begin
        mem[i] = {imm20, rd, OPC_AUIPC};
      end else begin
        span = 63 - i;
        if (span > 4) span = 4;        // short hops keep most of the program
        k    = 32'd1 + s % span;
        joff = 21'(k * 32'd4);
        mem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
      end
    end
    mem[63] = 32'h0000_0000;
    for (int i = 0; i < 64; i++) begin
      r            = $random(seed);
      ack_delay[i] = 3'd1 + {1'b0, r[1:0]};
    end
  endtask

  // walk the program once to know the retire count and halt pc
  task automatic predict_program();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] data;
    logic [4:0]  rd;
    logic        legal;
    int          steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    pc    = PC_RESET;
    legal = 1'b1;
    steps = 0;
    while (legal && steps < RETIRE_LIMIT) begin
      ref_exec(pc, mem[pc[7:2]], regs, rd, data, next_pc, legal);
      if (legal) begin
        if (rd != 5'd0) regs[rd] = data;
        pc = next_pc;
        predicted_count++;
      end
      steps++;
    end
    predicted_halt_pc = pc;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic halted;
    logic timed_out;
    int   wait_cycles;
    int   steps;
    int   run_errors;
    halted     = 1'b0;
    timed_out  = 1'b0;
    steps      = 0;
    run_errors = 0;
    seed       = 32'h09d020ee;
    fill_memory();
    predict_program();
    @(posedge clk);              // first reset edge
    idle_phase <= 1'b1;
    @(posedge clk);
    rst_n <= 1'b1;               // two cycles of reset
    repeat (3) @(posedge clk);
    start      <= 1'b1;
    idle_phase <= 1'b0;
    @(posedge clk);
    start <= 1'b0;
    while (!halted && !timed_out) begin
      wait_cycles = 0;
      @(posedge clk);
      while (!retire && !trap && wait_cycles < STEP_LIMIT) begin
        @(posedge clk);
        wait_cycles++;
      end
      if (trap) begin
        halted = 1'b1;
      end else if (!retire) begin
        timed_out = 1'b1;
        $display("timeout: no retire or trap within %0d cycles", STEP_LIMIT);
      end else begin
        steps++;
        if (steps > RETIRE_LIMIT) begin
          timed_out = 1'b1;
          $display("timeout: core kept retiring without reaching the trap");
        end
      end
    end
    if (halted) begin
      halt_phase <= 1'b1;        // nothing may move after the trap
      repeat (8) @(posedge clk);
    end else begin
      run_errors++;
    end
    if (retire_count != predicted_count) begin
      run_errors++;
      $display("core retired %0d instructions, model expects %0d",
               retire_count, predicted_count);
    end
    if (trap_count != 1) begin
      run_errors++;
      $display("expected one trap pulse, saw %0d", trap_count);
    end
    if (model_pc !== predicted_halt_pc) begin
      run_errors++;
      $display("halt pc %h differs from predicted %h", model_pc, predicted_halt_pc);
    end
    $display("done: %0d value errors, %0d run errors, %0d of %0d retired, %0d traps",
             error_count, run_errors, retire_count, predicted_count, trap_count);
    if (error_count == 0 && run_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
